// ==== Bender.yml ====
package:
  name: npc

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/npc_pkg.sv
      - rtl/npc_ctrl_if.sv
      - rtl/npc_decoder.sv
      - rtl/npc_regfile.sv
      - rtl/npc_alu.sv
      - rtl/npc_pc_counter.sv
      - rtl/npc_run_fsm.sv
      - rtl/npc_lsu.sv
      - rtl/npc_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/npc_tb.sv

// ==== compile.f ====
+incdir+rtl
rtl/npc_pkg.sv
rtl/npc_ctrl_if.sv
rtl/npc_decoder.sv
rtl/npc_regfile.sv
rtl/npc_alu.sv
rtl/npc_pc_counter.sv
rtl/npc_run_fsm.sv
rtl/npc_lsu.sv
rtl/npc_top.sv
verification/npc_tb.sv

// ==== rtl/npc_alu.sv ====
`timescale 1ns/1ns

module npc_alu import npc_pkg::*; (
    input npc_word_t pc,
    input npc_word_t src1,
    input npc_word_t src2,
    npc_ctrl_if.alu ctrl,
    output npc_word_t alu_result
);

    npc_word_t op1;
    npc_word_t op2;

    // operand muxes
    // pc only for auipc
    assign op1 = ctrl.src1_is_pc ? pc : src1;
    assign op2 = ctrl.src2_is_imm ? ctrl.imm : src2;

    always_comb begin
        case (ctrl.alu_op)
            alu_add: alu_result = op1 + op2;
            alu_sub: alu_result = op1 - op2;
            alu_xor: alu_result = op1 ^ op2;
            alu_or: alu_result = op1 | op2;
            // unsigned compare, 1 or 0
            alu_sltu: alu_result = {31'b0, op1 < op2};
            // branch condition for bne
            alu_ne: alu_result = {31'b0, op1 != op2};
            // shift amount from low five bits only
            alu_sra: alu_result = npc_word_t'($signed(op1) >>> op2[4:0]);
            default: alu_result = '0;
        endcase
    end

endmodule

// ==== rtl/npc_ctrl_if.sv ====
`timescale 1ns/1ns

interface npc_ctrl_if import npc_pkg::*; ();

    // register addresses
    npc_reg_addr_t rs1;
    npc_reg_addr_t rs2;
    npc_reg_addr_t rd;

    // selected immediate for this instruction group
    npc_word_t imm;

    // alu control
    npc_alu_op_t alu_op;
    logic src1_is_pc;
    logic src2_is_imm;

    // enables, not yet qualified by run
    logic reg_wen;
    logic mem_re;
    logic mem_we;
    logic is_byte;
    logic is_half;

    // flow control
    logic is_jal;
    logic is_jalr;
    logic is_bne;
    logic is_ebreak;

    npc_wb_src_t wb_src;

    modport decoder (
        output rs1, rs2, rd, imm, alu_op, src1_is_pc, src2_is_imm,
        output reg_wen, mem_re, mem_we, is_byte, is_half,
        output is_jal, is_jalr, is_bne, is_ebreak, wb_src
    );
    modport alu (input imm, alu_op, src1_is_pc, src2_is_imm);
    modport pc (input imm, is_jal, is_jalr, is_bne, is_ebreak);
    modport lsu (input imm, mem_re, mem_we, is_byte, is_half, wb_src);
    modport regfile (input rs1, rs2, rd, reg_wen);

endinterface

// ==== rtl/npc_decoder.sv ====
`timescale 1ns/1ns
`include "npc_macros.svh"

module npc_decoder import npc_pkg::*; (
    input npc_word_t inst,
    npc_ctrl_if.decoder ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    npc_word_t imm_i, imm_s, imm_b, imm_u, imm_j;
    logic grp_op, grp_op_imm, grp_load, grp_store;
    logic is_lui, is_auipc, is_jal, is_jalr;
    logic is_add, is_sub, is_xor, is_or, is_sltu;
    logic is_addi, is_sltiu, is_srai;
    logic is_lw, is_lbu, is_sb, is_sh, is_sw;
    logic is_bne, is_ebreak;

    // raw fields
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // immediates, all sign extended from inst[31] except u
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // group hits
    assign grp_op     = opcode == `NPC_OP_OP;
    assign grp_op_imm = opcode == `NPC_OP_OP_IMM;
    assign grp_load   = opcode == `NPC_OP_LOAD;
    assign grp_store  = opcode == `NPC_OP_STORE;

    // u and j types
    assign is_lui   = opcode == `NPC_OP_LUI;
    assign is_auipc = opcode == `NPC_OP_AUIPC;
    assign is_jal   = opcode == `NPC_OP_JAL;
    assign is_jalr  = (opcode == `NPC_OP_JALR) && (funct3 == 3'b000);

    // register alu, funct7 separates add from sub
    assign is_add  = grp_op && (funct3 == 3'b000) && (funct7 == 7'b0000000);
    assign is_sub  = grp_op && (funct3 == 3'b000) && (funct7 == 7'b0100000);
    assign is_xor  = grp_op && (funct3 == 3'b100) && (funct7 == 7'b0000000);
    assign is_or   = grp_op && (funct3 == 3'b110) && (funct7 == 7'b0000000);
    assign is_sltu = grp_op && (funct3 == 3'b011) && (funct7 == 7'b0000000);

    // immediate alu
    assign is_addi  = grp_op_imm && (funct3 == 3'b000);
    assign is_sltiu = grp_op_imm && (funct3 == 3'b011);
    assign is_srai  = grp_op_imm && (funct3 == 3'b101) && (funct7 == 7'b0100000);

    // loads and stores
    assign is_lw = grp_load && (funct3 == 3'b010);
    assign is_lbu = grp_load && (funct3 == 3'b100);
    assign is_sb = grp_store && (funct3 == 3'b000);
    assign is_sh = grp_store && (funct3 == 3'b001);
    assign is_sw = grp_store && (funct3 == 3'b010);

    assign is_bne = (opcode == `NPC_OP_BRANCH) && (funct3 == 3'b001);
    assign is_ebreak = inst == `NPC_EBREAK_INST;

    assign ctrl.rs1 = inst[19:15];
    assign ctrl.rs2 = inst[24:20];
    assign ctrl.rd  = inst[11:7];

    // immediate by instruction group
    always_comb begin
        case (opcode)
            `NPC_OP_LUI, `NPC_OP_AUIPC: ctrl.imm = imm_u;
            `NPC_OP_JAL: ctrl.imm = imm_j;
            `NPC_OP_BRANCH: ctrl.imm = imm_b;
            `NPC_OP_STORE: ctrl.imm = imm_s;
            `NPC_OP_JALR, `NPC_OP_OP_IMM, `NPC_OP_LOAD: ctrl.imm = imm_i;
            default: ctrl.imm = '0;
        endcase
    end

    // alu function, add covers auipc and address math
    always_comb begin
        if (is_sltu || is_sltiu) begin
            ctrl.alu_op = alu_sltu;
        end else if (is_bne) begin
            ctrl.alu_op = alu_ne;
        end else if (is_xor) begin
            ctrl.alu_op = alu_xor;
        end else if (is_or) begin
            ctrl.alu_op = alu_or;
        end else if (is_sub) begin
            ctrl.alu_op = alu_sub;
        end else if (is_srai) begin
            ctrl.alu_op = alu_sra;
        end else begin
            ctrl.alu_op = alu_add;
        end
    end

    assign ctrl.src1_is_pc  = is_auipc;
    assign ctrl.src2_is_imm = is_auipc | is_addi | is_sltiu | is_srai;

    // unrecognized encodings leave every enable low
    assign ctrl.reg_wen = is_lui | is_auipc | is_jal | is_jalr
                        | is_add | is_sub | is_xor | is_or | is_sltu
                        | is_addi | is_sltiu | is_srai | is_lw | is_lbu;
    assign ctrl.mem_re  = is_lw | is_lbu;
    assign ctrl.mem_we  = is_sb | is_sh | is_sw;
    assign ctrl.is_byte = is_sb | is_lbu;
    assign ctrl.is_half = is_sh;

    assign ctrl.is_jal    = is_jal;
    assign ctrl.is_jalr   = is_jalr;
    assign ctrl.is_bne    = is_bne;
    assign ctrl.is_ebreak = is_ebreak;

    always_comb begin
        if (is_lw || is_lbu) begin
            ctrl.wb_src = wb_mem;
        end else if (is_jal || is_jalr) begin
            ctrl.wb_src = wb_pc_plus_4;
        end else if (is_lui) begin
            ctrl.wb_src = wb_imm;
        end else begin
            ctrl.wb_src = wb_alu;
        end
    end

    // a store never writes a register as well
    always_comb begin
        assert final (!(ctrl.reg_wen && ctrl.mem_we))
            else $error("decoder raised reg_wen and mem_we together");
    end

endmodule

// ==== rtl/npc_lsu.sv ====
`timescale 1ns/1ns

module npc_lsu import npc_pkg::*; (
    input logic run,
    npc_ctrl_if.lsu ctrl,
    input npc_word_t pc,
    input npc_word_t src1,
    input npc_word_t src2,
    input npc_word_t alu_result,
    output npc_word_t dmem_addr,
    output logic dmem_re,
    output logic dmem_we,
    output npc_byte_mask_t dmem_wmask,
    output npc_word_t dmem_wdata,
    input npc_word_t dmem_rdata,
    output npc_word_t wb_data
);

    npc_word_t eff_addr;
    logic [1:0] byte_off;
    npc_byte_mask_t lane_mask;
    npc_word_t rdata_shifted;
    npc_word_t load_data;

    // effective address, word aligned toward memory
    assign eff_addr = src1 + ctrl.imm;
    assign byte_off = eff_addr[1:0];
    assign dmem_addr = {eff_addr[31:2], 2'b00};

    assign dmem_re = ctrl.mem_re;
    assign dmem_we = run && ctrl.mem_we;

    // lanes before shifting to the byte offset
    always_comb begin
        if (ctrl.is_byte) begin
            lane_mask = 4'b0001;
        end else if (ctrl.is_half) begin
            lane_mask = 4'b0011;
        end else begin
            lane_mask = 4'b1111;
        end
    end

    assign dmem_wmask = dmem_we ? npc_byte_mask_t'(lane_mask << byte_off) : '0;
    assign dmem_wdata = src2 << {byte_off, 3'b000};

    // lbu picks the addressed byte, lw takes the word as is
    assign rdata_shifted = dmem_rdata >> {byte_off, 3'b000};
    assign load_data = ctrl.is_byte ? {24'b0, rdata_shifted[7:0]} : dmem_rdata;

    // write-back select
    always_comb begin
        case (ctrl.wb_src)
            wb_mem: wb_data = load_data;
            wb_pc_plus_4: wb_data = pc + 32'd4;
            wb_imm: wb_data = ctrl.imm;
            default: wb_data = alu_result;
        endcase
    end

    // no strobes leak out of a non-committing cycle
    always_comb begin
        assert final (dmem_we || (dmem_wmask == '0))
            else $error("dmem_wmask %b without dmem_we", dmem_wmask);
    end

endmodule

// ==== rtl/npc_macros.svh ====
`ifndef NPC_MACROS_SVH
`define NPC_MACROS_SVH

// first fetch address out of reset
`define NPC_RESET_VECTOR 32'h8000_0000

// full ebreak encoding, matched as a whole word
`define NPC_EBREAK_INST 32'h0010_0073

// major opcode groups, inst[6:0]
`define NPC_OP_LUI    7'b0110111
`define NPC_OP_AUIPC  7'b0010111
`define NPC_OP_JAL    7'b1101111
`define NPC_OP_JALR   7'b1100111
`define NPC_OP_OP     7'b0110011
`define NPC_OP_OP_IMM 7'b0010011
`define NPC_OP_LOAD   7'b0000011
`define NPC_OP_STORE  7'b0100011
`define NPC_OP_BRANCH 7'b1100011

`endif

// ==== rtl/npc_pc_counter.sv ====
`timescale 1ns/1ns
`include "npc_macros.svh"

module npc_pc_counter import npc_pkg::*; (
    input logic clk,
    input logic reset,
    input logic run,
    npc_ctrl_if.pc ctrl,
    input npc_word_t src1,
    input npc_word_t alu_result,
    output npc_word_t pc
);

    npc_word_t next_pc;
    npc_word_t jalr_target;
    logic branch_taken;

    // bne taken when the alu reports not equal
    assign branch_taken = ctrl.is_bne && (alu_result == 32'd1);

    // jalr clears bit 0 of the sum
    assign jalr_target = (src1 + ctrl.imm) & ~32'd1;

    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = jalr_target;
        end else if (ctrl.is_jal || branch_taken) begin
            next_pc = pc + ctrl.imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // held whenever nothing commits
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `NPC_RESET_VECTOR;
        end else if (run) begin
            pc <= next_pc;
        end
    end

    pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("pc %h not word aligned", pc);

endmodule

// ==== rtl/npc_pkg.sv ====
package npc_pkg;

    // data word, address or raw instruction
    typedef logic [31:0] npc_word_t;

    // register index, x0..x31
    typedef logic [4:0] npc_reg_addr_t;

    // one write strobe per byte lane
    typedef logic [3:0] npc_byte_mask_t;

    // alu function select
    // ne yields 1 or 0, used for bne
    typedef enum logic [2:0] {
        alu_add,
        alu_sltu,
        alu_ne,
        alu_xor,
        alu_or,
        alu_sub,
        alu_sra
    } npc_alu_op_t;

    // run control
    typedef enum logic [1:0] {
        st_reset,
        st_run,
        st_halted
    } npc_run_state_t;

    // register write-back source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus_4,
        wb_imm
    } npc_wb_src_t;

endpackage

// ==== rtl/npc_regfile.sv ====
`timescale 1ns/1ns

module npc_regfile import npc_pkg::*; (
    input logic clk,
    input logic reset,
    input logic run,
    npc_ctrl_if.regfile ctrl,
    input npc_word_t wb_data,
    output npc_word_t src1,
    output npc_word_t src2
);

    npc_word_t regs [32];

    // write port, x0 writes dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (run && ctrl.reg_wen && (ctrl.rd != '0)) begin
            regs[ctrl.rd] <= wb_data;
        end
    end

    // combinational reads
    // x0 forced to zero even before the first reset
    assign src1 = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
    assign src2 = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

    // x0 storage stays clear across all commits
    x0_zero: assert property (
        @(posedge clk) disable iff (reset)
        regs[0] == '0
    ) else $error("regfile entry 0 holds %h", regs[0]);

endmodule

// ==== rtl/npc_run_fsm.sv ====
`timescale 1ns/1ns

module npc_run_fsm import npc_pkg::*; (
    input logic clk,
    input logic reset,
    npc_ctrl_if.pc ctrl,
    output logic run,
    output logic halted
);

    npc_run_state_t state;
    npc_run_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            // one idle cycle after reset
            st_reset: state_next = st_run;
            st_run: begin
                if (ctrl.is_ebreak) begin
                    state_next = st_halted;
                end
            end
            // only reset leaves halted
            st_halted: state_next = st_halted;
            default: state_next = st_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_reset;
        end else begin
            state <= state_next;
        end
    end

    // commit enable, ebreak itself commits nothing
    assign run = (state == st_run) && !ctrl.is_ebreak;
    assign halted = state == st_halted;

    halt_sticky: assert property (
        @(posedge clk) disable iff (reset)
        (state == st_halted) |=> (state == st_halted)
    ) else $error("run fsm left halted without reset");

endmodule

// ==== rtl/npc_top.sv ====
`timescale 1ns/1ns

module npc_top import npc_pkg::*; (
    input logic clk,
    input logic reset,
    // instruction memory, combinational read
    output npc_word_t pc,
    input npc_word_t inst,
    // data memory
    output npc_word_t dmem_addr,
    output logic dmem_re,
    input npc_word_t dmem_rdata,
    output logic dmem_we,
    output npc_byte_mask_t dmem_wmask,
    output npc_word_t dmem_wdata,
    // run control
    output logic halted
);

    npc_word_t src1;
    npc_word_t src2;
    npc_word_t alu_result;
    npc_word_t wb_data;
    logic run;

    // decoded control, one driver
    npc_ctrl_if ctrl_if ();

    npc_decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl_if.decoder)
    );

    npc_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .ctrl    (ctrl_if.regfile),
        .wb_data (wb_data),
        .src1    (src1),
        .src2    (src2)
    );

    npc_alu u_alu (
        .pc         (pc),
        .src1       (src1),
        .src2       (src2),
        .ctrl       (ctrl_if.alu),
        .alu_result (alu_result)
    );

    npc_pc_counter u_pc_counter (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .ctrl       (ctrl_if.pc),
        .src1       (src1),
        .alu_result (alu_result),
        .pc         (pc)
    );

    // commit enable for pc, regfile and stores
    npc_run_fsm u_run_fsm (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl_if.pc),
        .run    (run),
        .halted (halted)
    );

    npc_lsu u_lsu (
        .run        (run),
        .ctrl       (ctrl_if.lsu),
        .pc         (pc),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result),
        .dmem_addr  (dmem_addr),
        .dmem_re    (dmem_re),
        .dmem_we    (dmem_we),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .wb_data    (wb_data)
    );

endmodule

// ==== verification/npc_tb.sv ====
`timescale 1ns/1ns
`include "npc_macros.svh"

module npc_tb import npc_pkg::*; ();

    localparam npc_word_t data_base = 32'h0000_1000;
    localparam int result_off = 'h100;
    localparam int imem_words = 256;
    localparam int dmem_words = 128;
    localparam int halt_timeout = 2000;

    logic clk;
    logic reset;
    npc_word_t pc;
    npc_word_t inst;
    npc_word_t dmem_addr;
    npc_word_t dmem_rdata;
    npc_word_t dmem_wdata;
    logic dmem_re;
    logic dmem_we;
    logic halted;
    npc_byte_mask_t dmem_wmask;

    npc_word_t imem [imem_words];
    npc_word_t dmem [dmem_words];

    // expected stores by word address
    npc_byte_mask_t exp_mask [npc_word_t];
    npc_word_t exp_data [npc_word_t];
    string exp_name [npc_word_t];
    bit seen [npc_word_t];
    // addresses only a wrong path would store to
    bit skipped [npc_word_t];

    int prog_len;
    int next_slot;
    int pass_count;
    int fail_count;
    npc_word_t rng;
    npc_word_t op_a;
    npc_word_t op_b;
    npc_word_t op_c;

    npc_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .inst       (inst),
        .dmem_addr  (dmem_addr),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata),
        .dmem_we    (dmem_we),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // combinational memory reads
    assign inst = imem[pc[9:2]];
    // read data only valid while dmem_re is high
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[8:2]] : 'x;

    // byte-lane writes at the edge
    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dmem_we && dmem_wmask[b]) begin
                dmem[dmem_addr[8:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && dmem_we) begin
            check_store(dmem_addr, dmem_wmask, dmem_wdata);
        end
    end

    // outputs settle to reset values one edge into reset
    reset_quiet: assert property (
        @(posedge clk) reset |->
            ##1 ((pc == `NPC_RESET_VECTOR) && !dmem_we && !dmem_re && !halted)
    ) else begin
        fail_count++;
        $display("pc, dmem_we, dmem_re or halted left their reset values while in reset");
    end

    // nothing moves once halted
    halt_hold: assert property (
        @(posedge clk) disable iff (reset)
        halted |=> (halted && $stable(pc) && !dmem_we)
    ) else begin
        fail_count++;
        $display("core changed pc, stored or left halted after ebreak");
    end

    function automatic npc_word_t xorshift(input npc_word_t x);
        npc_word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic npc_word_t lane_bits(input npc_byte_mask_t m);
        npc_word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = {8{m[b]}};
        end
        return w;
    endfunction

    // instruction formats
    function automatic npc_word_t r_type(input logic [6:0] f7, input npc_reg_addr_t rs2,
                                         input npc_reg_addr_t rs1, input logic [2:0] f3,
                                         input npc_reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `NPC_OP_OP};
    endfunction

    function automatic npc_word_t i_type(input logic [6:0] op, input logic [11:0] imm,
                                         input npc_reg_addr_t rs1, input logic [2:0] f3,
                                         input npc_reg_addr_t rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic npc_word_t s_type(input logic [2:0] f3, input npc_reg_addr_t rs2,
                                         input npc_reg_addr_t rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `NPC_OP_STORE};
    endfunction

    function automatic npc_word_t b_type(input logic [2:0] f3, input npc_reg_addr_t rs1,
                                         input npc_reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `NPC_OP_BRANCH};
    endfunction

    function automatic npc_word_t u_type(input logic [6:0] op, input logic [19:0] imm,
                                         input npc_reg_addr_t rd);
        return {imm, rd, op};
    endfunction

    function automatic npc_word_t j_type(input npc_reg_addr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `NPC_OP_JAL};
    endfunction

    function automatic npc_word_t current_pc();
        return `NPC_RESET_VECTOR + 32'(4 * prog_len);
    endfunction

    task automatic emit(input npc_word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // store rs into the next result slot relative to x1
    // x1 holds data_base
    task automatic place_store(input string name, input logic [2:0] f3, input npc_reg_addr_t rs,
                               input int lane, input npc_byte_mask_t mask, input npc_word_t data);
        npc_word_t addr;
        addr = data_base + 32'(result_off + 4 * next_slot);
        emit(s_type(f3, rs, 5'd1, 12'(result_off + 4 * next_slot + lane)));
        exp_mask[addr] = mask;
        exp_data[addr] = data;
        exp_name[addr] = name;
        next_slot++;
    endtask

    task automatic store_result(input string name, input npc_reg_addr_t rs, input npc_word_t data);
        place_store(name, 3'b010, rs, 0, 4'hf, data);
    endtask

    task automatic skipped_store();
        skipped[data_base + 32'(result_off + 4 * next_slot)] = 1'b1;
        emit(s_type(3'b010, 5'd2, 5'd1, 12'(result_off + 4 * next_slot)));
        next_slot++;
    endtask

    task automatic check_store(input npc_word_t addr, input npc_byte_mask_t mask,
                               input npc_word_t data);
        npc_word_t lanes;
        if (skipped.exists(addr)) begin
            fail_count++;
            $display("store to %h came from a path that should have been skipped", addr);
        end else if (!exp_name.exists(addr)) begin
            fail_count++;
            $display("store to unexpected address %h", addr);
        end else begin
            lanes = lane_bits(exp_mask[addr]);
            seen[addr] = 1'b1;
            store_value: assert ((mask == exp_mask[addr])
                                 && ((data & lanes) == (exp_data[addr] & lanes))) begin
                pass_count++;
                $display("passed %s", exp_name[addr]);
            end else begin
                fail_count++;
                $display("FAILED %s expected %h mask %b actual %h mask %b", exp_name[addr],
                         exp_data[addr] & lanes, exp_mask[addr], data & lanes, mask);
            end
        end
    endtask

    task automatic check_reset_values(inout bit ok);
        reset_values: assert ((pc == `NPC_RESET_VECTOR) && !dmem_we && !dmem_re && !halted)
        else begin
            ok = 1'b0;
            $display({"FAILED reset expected pc %h we 0 re 0 halted 0",
                      " actual pc %h we %b re %b halted %b"},
                     `NPC_RESET_VECTOR, pc, dmem_we, dmem_re, halted);
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
            $display("passed %s", name);
        end else begin
            fail_count++;
            $display("test %s did not pass", name);
        end
    endtask

    task automatic build_program();
        logic [19:0] ui;
        logic [11:0] imm12;
        logic [4:0] shamt;
        npc_word_t link_pc;
        // x1 = data_base
        // x2 and x3 hold operands a and b
        emit(u_type(`NPC_OP_LUI, 20'h00001, 5'd1));
        emit(i_type(`NPC_OP_LOAD, 12'd0, 5'd1, 3'b010, 5'd2));
        emit(i_type(`NPC_OP_LOAD, 12'd4, 5'd1, 3'b010, 5'd3));
        // alu results all stored from x4
        rng = xorshift(rng);
        ui = rng[19:0];
        emit(u_type(`NPC_OP_LUI, ui, 5'd4));
        store_result("lui", 5'd4, {ui, 12'b0});
        link_pc = current_pc();
        emit(u_type(`NPC_OP_AUIPC, ~ui, 5'd4));
        store_result("auipc", 5'd4, link_pc + {~ui, 12'b0});
        rng = xorshift(rng);
        imm12 = rng[11:0];
        emit(i_type(`NPC_OP_OP_IMM, imm12, 5'd2, 3'b000, 5'd4));
        store_result("addi", 5'd4, op_a + {{20{imm12[11]}}, imm12});
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4));
        store_result("add", 5'd4, op_a + op_b);
        emit(r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd4));
        store_result("sub", 5'd4, op_a - op_b);
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd4));
        store_result("xor", 5'd4, op_a ^ op_b);
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd4));
        store_result("or", 5'd4, op_a | op_b);
        emit(r_type(7'h00, 5'd3, 5'd2, 3'b011, 5'd4));
        store_result("sltu", 5'd4, {31'b0, op_a < op_b});
        rng = xorshift(rng);
        imm12 = rng[27:16];
        emit(i_type(`NPC_OP_OP_IMM, imm12, 5'd2, 3'b011, 5'd4));
        store_result("sltiu", 5'd4, {31'b0, op_a < {{20{imm12[11]}}, imm12}});
        shamt = rng[4:0];
        emit(i_type(`NPC_OP_OP_IMM, {7'b0100000, shamt}, 5'd2, 3'b101, 5'd4));
        // vacated upper bits filled with the sign bit
        store_result("srai", 5'd4,
                     op_a[31] ? ((op_a >> shamt) | ~(32'hffff_ffff >> shamt))
                              : (op_a >> shamt));
        // byte and halfword lanes
        for (int lane = 0; lane < 4; lane++) begin
            place_store($sformatf("sb lane %0d", lane), 3'b000, 5'd2, lane,
                        npc_byte_mask_t'(4'b0001 << lane), {24'b0, op_a[7:0]} << (8 * lane));
        end
        for (int lane = 0; lane < 4; lane += 2) begin
            place_store($sformatf("sh lane %0d", lane), 3'b001, 5'd2, lane,
                        npc_byte_mask_t'(4'b0011 << lane), {16'b0, op_a[15:0]} << (8 * lane));
        end
        for (int lane = 0; lane < 4; lane++) begin
            emit(i_type(`NPC_OP_LOAD, 12'(lane), 5'd1, 3'b100, 5'd5));
            store_result($sformatf("lbu lane %0d", lane), 5'd5, (op_a >> (8 * lane)) & 32'hff);
        end
        emit(i_type(`NPC_OP_LOAD, 12'd8, 5'd1, 3'b010, 5'd5));
        store_result("lw", 5'd5, op_c);
        // bne taken since a and b always differ
        emit(b_type(3'b001, 5'd2, 5'd3, 13'd8));
        skipped_store();
        emit(b_type(3'b001, 5'd2, 5'd2, 13'd8));
        store_result("bne not taken", 5'd3, op_b);
        // jal forward over a skipped store and back into a forward hop
        emit(j_type(5'd0, 21'd12));
        skipped_store();
        emit(j_type(5'd0, 21'd12));
        store_result("jal forward", 5'd2, op_a);
        link_pc = current_pc();
        emit(j_type(5'd7, -21'd8));
        store_result("jal back link", 5'd7, link_pc + 32'd4);
        // jalr to an odd offset lands 4 words past the auipc
        emit(u_type(`NPC_OP_AUIPC, 20'h0, 5'd8));
        link_pc = current_pc();
        emit(i_type(`NPC_OP_JALR, 12'd17, 5'd8, 3'b000, 5'd9));
        skipped_store();
        skipped_store();
        store_result("jalr forward link", 5'd9, link_pc + 32'd4);
        // jalr back to the marker two words after the auipc
        emit(u_type(`NPC_OP_AUIPC, 20'h0, 5'd8));
        emit(j_type(5'd0, 21'd12));
        store_result("jalr back", 5'd2, op_a);
        emit(j_type(5'd0, 21'd12));
        link_pc = current_pc();
        emit(i_type(`NPC_OP_JALR, 12'd9, 5'd8, 3'b000, 5'd10));
        skipped_store();
        store_result("jalr back link", 5'd10, link_pc + 32'd4);
        // x0 write must vanish
        emit(i_type(`NPC_OP_OP_IMM, 12'h055, 5'd2, 3'b000, 5'd0));
        store_result("x0 discard", 5'd0, 32'd0);
        emit(`NPC_EBREAK_INST);
    endtask

    initial begin
        npc_word_t halt_pc;
        bit reset_ok;
        bit halt_ok;
        bit timed_out;
        reset = 1'b1;
        prog_len = 0;
        next_slot = 0;
        pass_count = 0;
        fail_count = 0;
        rng = 32'd32403;
        // fill pattern from each word's byte address
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = (data_base + 32'(4 * i)) ^ 32'h3c5a_96e1;
        end
        rng = xorshift(rng);
        op_a = rng;
        rng = xorshift(rng);
        op_b = (rng == op_a) ? ~op_a : rng;
        rng = xorshift(rng);
        op_c = rng;
        dmem[0] = op_a;
        dmem[1] = op_b;
        dmem[2] = op_c;
        build_program();

        // 16 reset cycles with pc checked from the second edge on
        reset_ok = 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_reset_values(reset_ok);
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        check_reset_values(reset_ok);
        report_test("reset", reset_ok);

        timed_out = 1'b1;
        for (int cycles = 0; cycles < halt_timeout; cycles++) begin
            @(posedge clk);
            if (halted) begin
                timed_out = 1'b0;
                break;
            end
        end

        if (timed_out) begin
            fail_count++;
            $display("core never halted within %0d cycles", halt_timeout);
        end else begin
            halt_ok = 1'b1;
            halt_pc = pc;
            repeat (20) begin
                @(posedge clk);
                halt_quiet: assert ((pc == halt_pc) && !dmem_we && halted)
                else begin
                    halt_ok = 1'b0;
                    $display("FAILED halt expected pc %h we 0 actual pc %h we %b",
                             halt_pc, pc, dmem_we);
                end
            end
            report_test("halt", halt_ok);
        end

        foreach (exp_name[addr]) begin
            if (!seen.exists(addr)) begin
                fail_count++;
                $display("store for %s never happened", exp_name[addr]);
            end
        end

        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
